//--- Bender.yml
package:
  name: riscvPipe

sources:
  - hw/rvPkg.sv
  - hw/fetchStage.sv
  - hw/decodeStage.sv
  - hw/executeStage.sv
  - hw/memWbStage.sv
  - hw/riscvTop.sv
  - target: test
    files:
      - tests/tbMemories.sv
      - tests/tbRiscvTop.sv

//--- hw/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
   input  logic                       CLK,
   input  logic                       RSTn,
   input  logic [rvPkg::xlen-1:0]     instId,
   input  logic [rvPkg::xlen-1:0]     pcId,
   input  logic                       validId,
   input  logic                       flush,
   input  logic [rvPkg::xlen-1:0]     rfRd1,
   input  logic [rvPkg::xlen-1:0]     rfRd2,
   input  rvPkg::memWbT               wbFwd,
   output logic [rvPkg::regAddrW-1:0] rfRa1,
   output logic [rvPkg::regAddrW-1:0] rfRa2,
   output logic                       stall,
   output logic                       haltFetch,
   output rvPkg::idExT                idEx
);

   logic [rvPkg::regAddrW-1:0] rs1;
   logic [rvPkg::regAddrW-1:0] rs2;
   logic [rvPkg::regAddrW-1:0] rd;
   rvPkg::opcodeE              opcode;
   rvPkg::ctrlT                ctrl;
   logic [rvPkg::xlen-1:0]     imm;
   logic [rvPkg::xlen-1:0]     rs1Val;
   logic [rvPkg::xlen-1:0]     rs2Val;
   logic                       useRs1;
   logic                       useRs2;
   logic                       loadUse;

   function automatic rvPkg::aluOpE aluDecode(input logic [2:0] funct3, input logic alt);
      rvPkg::aluOpE op;
      case (funct3)
         3'b000:  op = alt ? rvPkg::aluSub : rvPkg::aluAdd;
         3'b001:  op = rvPkg::aluSll;
         3'b010:  op = rvPkg::aluSlt;
         3'b011:  op = rvPkg::aluSltu;
         3'b100:  op = rvPkg::aluXor;
         3'b101:  op = alt ? rvPkg::aluSra : rvPkg::aluSrl;
         3'b110:  op = rvPkg::aluOr;
         default: op = rvPkg::aluAnd;
      endcase
      return op;
   endfunction

   assign rs1 = instId[19:15];
   assign rs2 = instId[24:20];
   assign rd = instId[11:7];
   assign opcode = rvPkg::opcodeE'(instId[6:0]);
   assign rfRa1 = rs1;
   assign rfRa2 = rs2;

   always_comb begin
      ctrl = '0;
      imm = '0;
      useRs1 = 1'b0;
      useRs2 = 1'b0;
      ctrl.brCond = instId[14:12];
      case (opcode)
         rvPkg::opReg: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluOp = aluDecode(instId[14:12], instId[30]);
            useRs1 = 1'b1;
            useRs2 = 1'b1;
         end
         rvPkg::opImm: begin
            ctrl.regWrite = 1'b1;
            ctrl.srcBImm = 1'b1;
            // bit 30 picks sub only for registers, for immediates only srai
            ctrl.aluOp = aluDecode(instId[14:12], instId[30] && instId[14:12] == 3'b101);
            imm = {{20{instId[31]}}, instId[31:20]};
            useRs1 = 1'b1;
         end
         rvPkg::opLoad: begin
            ctrl.regWrite = 1'b1;
            ctrl.memRead = 1'b1;
            ctrl.srcBImm = 1'b1;
            imm = {{20{instId[31]}}, instId[31:20]};
            useRs1 = 1'b1;
         end
         rvPkg::opStore: begin
            ctrl.memWrite = 1'b1;
            ctrl.srcBImm = 1'b1;
            imm = {{20{instId[31]}}, instId[31:25], instId[11:7]};
            useRs1 = 1'b1;
            useRs2 = 1'b1;
         end
         rvPkg::opBranch: begin
            ctrl.isBranch = 1'b1;
            imm = {{19{instId[31]}}, instId[31], instId[7], instId[30:25], instId[11:8], 1'b0};
            useRs1 = 1'b1;
            useRs2 = 1'b1;
         end
         rvPkg::opJal: begin
            ctrl.regWrite = 1'b1;
            ctrl.isJal = 1'b1;
            ctrl.srcAPc = 1'b1;   // target is pc + imm through the alu
            ctrl.srcBImm = 1'b1;
            imm = {{11{instId[31]}}, instId[31], instId[19:12], instId[20], instId[30:21], 1'b0};
         end
         rvPkg::opJalr: begin
            ctrl.regWrite = 1'b1;
            ctrl.isJalr = 1'b1;
            ctrl.srcBImm = 1'b1;
            imm = {{20{instId[31]}}, instId[31:20]};
            useRs1 = 1'b1;
         end
         rvPkg::opSystem: ctrl.isHalt = 1'b1;
         default: ;
      endcase
      if (rd == '0) begin
         ctrl.regWrite = 1'b0;   // x0 never written
      end
   end

   // WB writes the register file at the same edge, so take its value here
   assign rs1Val = (wbFwd.valid && wbFwd.regWrite && wbFwd.rd == rs1) ? wbFwd.wdata : rfRd1;
   assign rs2Val = (wbFwd.valid && wbFwd.regWrite && wbFwd.rd == rs2) ? wbFwd.wdata : rfRd2;

   // load in EX feeding this instruction
   assign loadUse = idEx.valid && idEx.ctrl.memRead && idEx.ctrl.regWrite &&
                    ((useRs1 && rs1 == idEx.rd) || (useRs2 && rs2 == idEx.rd));
   assign stall = validId && loadUse;
   assign haltFetch = validId && !flush && ctrl.isHalt;

   always_ff @(posedge CLK) begin
      if (RSTn) begin
         idEx.valid <= 1'b0;
         idEx.ctrl <= '0;
      end else if (flush || stall || !validId) begin
         idEx.valid <= 1'b0;   // bubble
         idEx.ctrl <= '0;
      end else begin
         idEx.valid <= 1'b1;
         idEx.ctrl <= ctrl;
      end
   end

   always_ff @(posedge CLK) begin
      idEx.pc <= pcId;
      idEx.rs1Val <= rs1Val;
      idEx.rs2Val <= rs2Val;
      idEx.rs1 <= rs1;
      idEx.rs2 <= rs2;
      idEx.rd <= rd;
      idEx.imm <= imm;
   end

   // a load in EX never redirects
   stallFlushExclusive: assert property (@(posedge CLK) disable iff (RSTn)
      idEx.valid |-> !(stall && flush));

endmodule

//--- hw/executeStage.sv
`timescale 1ns/1ps

module executeStage (
   input  logic                   CLK,
   input  logic                   RSTn,
   input  rvPkg::idExT            idEx,
   input  rvPkg::exMemT           memFwd,
   input  rvPkg::memWbT           wbFwd,
   output logic                   redirect,
   output logic [rvPkg::xlen-1:0] redirectPc,
   output rvPkg::exMemT           exMem
);

   logic [rvPkg::xlen-1:0] rs1Fwd;
   logic [rvPkg::xlen-1:0] rs2Fwd;
   logic [rvPkg::xlen-1:0] opA;
   logic [rvPkg::xlen-1:0] opB;
   logic [rvPkg::xlen-1:0] aluY;
   logic [rvPkg::xlen-1:0] linkPc;
   logic                   taken;
   logic                   isJump;

   function automatic logic [rvPkg::xlen-1:0] pickOperand(
      input logic [rvPkg::regAddrW-1:0] src,
      input logic [rvPkg::xlen-1:0]     idVal,
      input rvPkg::exMemT               m,
      input rvPkg::memWbT               w
   );
      logic [rvPkg::xlen-1:0] val;
      val = idVal;
      if (w.valid && w.regWrite && w.rd == src) begin
         val = w.wdata;
      end
      // MEM is younger and overrides WB, a load there is covered by the stall
      if (m.valid && m.regWrite && !m.memRead && m.rd == src) begin
         val = m.aluResult;
      end
      return val;
   endfunction

   assign rs1Fwd = pickOperand(idEx.rs1, idEx.rs1Val, memFwd, wbFwd);
   assign rs2Fwd = pickOperand(idEx.rs2, idEx.rs2Val, memFwd, wbFwd);
   assign opA = idEx.ctrl.srcAPc ? idEx.pc : rs1Fwd;
   assign opB = idEx.ctrl.srcBImm ? idEx.imm : rs2Fwd;

   always_comb begin
      case (idEx.ctrl.aluOp)
         rvPkg::aluSub:  aluY = opA - opB;
         rvPkg::aluSll:  aluY = opA << opB[4:0];
         rvPkg::aluSlt:  aluY = {{(rvPkg::xlen-1){1'b0}}, $signed(opA) < $signed(opB)};
         rvPkg::aluSltu: aluY = {{(rvPkg::xlen-1){1'b0}}, opA < opB};
         rvPkg::aluXor:  aluY = opA ^ opB;
         rvPkg::aluSrl:  aluY = opA >> opB[4:0];
         rvPkg::aluSra:  aluY = $signed(opA) >>> opB[4:0];
         rvPkg::aluOr:   aluY = opA | opB;
         rvPkg::aluAnd:  aluY = opA & opB;
         default:        aluY = opA + opB;   // add, address and jump target
      endcase
   end

   always_comb begin
      case (idEx.ctrl.brCond)
         3'b000:  taken = rs1Fwd == rs2Fwd;
         3'b001:  taken = rs1Fwd != rs2Fwd;
         3'b100:  taken = $signed(rs1Fwd) < $signed(rs2Fwd);
         3'b101:  taken = $signed(rs1Fwd) >= $signed(rs2Fwd);
         3'b110:  taken = rs1Fwd < rs2Fwd;
         3'b111:  taken = rs1Fwd >= rs2Fwd;
         default: taken = 1'b0;
      endcase
   end

   assign isJump = idEx.ctrl.isJal || idEx.ctrl.isJalr;
   assign linkPc = idEx.pc + 4;
   assign redirect = idEx.valid && (isJump || (idEx.ctrl.isBranch && taken));
   // jalr clears bit 0 of the target
   assign redirectPc = isJump ? {aluY[rvPkg::xlen-1:1], 1'b0} : idEx.pc + idEx.imm;

   always_ff @(posedge CLK) begin
      if (RSTn) begin
         exMem.valid <= 1'b0;
         exMem.regWrite <= 1'b0;
         exMem.memRead <= 1'b0;
         exMem.memWrite <= 1'b0;
         exMem.isHalt <= 1'b0;
      end else begin
         exMem.valid <= idEx.valid;
         exMem.regWrite <= idEx.ctrl.regWrite;
         exMem.memRead <= idEx.ctrl.memRead;
         exMem.memWrite <= idEx.ctrl.memWrite;
         exMem.isHalt <= idEx.ctrl.isHalt;
      end
   end

   always_ff @(posedge CLK) begin
      exMem.aluResult <= isJump ? linkPc : aluY;
      exMem.storeData <= rs2Fwd;
      exMem.rd <= idEx.rd;
   end

endmodule

//--- hw/fetchStage.sv
`timescale 1ns/1ps

module fetchStage #(
   parameter int addrWidth = 12
) (
   input  logic                   CLK,
   input  logic                   RSTn,
   input  logic                   stall,
   input  logic                   haltFetch,
   input  logic                   redirect,
   input  logic [rvPkg::xlen-1:0] redirectPc,
   input  logic [rvPkg::xlen-1:0] iMemData,
   output logic [addrWidth-1:0]   iMemAddr,
   output logic                   iMemCsn,
   output logic [rvPkg::xlen-1:0] instId,
   output logic [rvPkg::xlen-1:0] pcId,
   output logic                   validId
);

   logic [rvPkg::xlen-1:0] pc;
   logic                   fetchHalted;   // set once a SYSTEM op is decoded

   assign iMemAddr = pc[addrWidth-1:0];   // byte address
   assign iMemCsn = RSTn;

   always_ff @(posedge CLK) begin
      if (RSTn) begin
         pc <= '0;
         validId <= 1'b0;
         fetchHalted <= 1'b0;
      end else if (redirect) begin
         pc <= redirectPc;
         validId <= 1'b0;   // wrong-path fetch dropped
      end else if (haltFetch || fetchHalted) begin
         fetchHalted <= 1'b1;
         validId <= 1'b0;
      end else if (!stall) begin
         pc <= pc + 4;
         validId <= 1'b1;
      end
   end

   // IF/ID payload held while decode stalls
   always_ff @(posedge CLK) begin
      if (!stall) begin
         instId <= iMemData;
         pcId <= pc;
      end
   end

   // jump targets coming back from execute must keep fetch aligned
   alignedTarget: assert property (@(posedge CLK) disable iff (RSTn)
      redirect |=> iMemAddr[1:0] == 2'b00);

endmodule

//--- hw/memWbStage.sv
`timescale 1ns/1ps

module memWbStage #(
   parameter int addrWidth = 12
) (
   input  logic                       CLK,
   input  logic                       RSTn,
   input  rvPkg::exMemT               exMem,
   input  logic [rvPkg::xlen-1:0]     dMemRdata,
   output logic [addrWidth-1:0]       dMemAddr,
   output logic [rvPkg::xlen-1:0]     dMemWdata,
   output logic                       dMemWen,
   output logic                       dMemCsn,
   output rvPkg::memWbT               wbFwd,
   output logic                       rfWe,
   output logic [rvPkg::regAddrW-1:0] rfWa,
   output logic [rvPkg::xlen-1:0]     rfWd,
   output logic                       halt,
   output logic [rvPkg::xlen-1:0]     numInst
);

   rvPkg::memWbT memWb;
   logic         haltSeen;
   logic         haltRetire;   // SYSTEM op sitting in WB

   assign dMemAddr = exMem.aluResult[addrWidth-1:0];   // byte address
   assign dMemWdata = exMem.storeData;
   assign dMemWen = !(exMem.valid && exMem.memWrite);   // active low
   assign dMemCsn = RSTn;

   always_ff @(posedge CLK) begin
      if (RSTn) begin
         memWb.valid <= 1'b0;
         memWb.regWrite <= 1'b0;
         memWb.isHalt <= 1'b0;
      end else begin
         memWb.valid <= exMem.valid;
         memWb.regWrite <= exMem.valid && exMem.regWrite;
         memWb.isHalt <= exMem.valid && exMem.isHalt;
      end
   end

   always_ff @(posedge CLK) begin
      memWb.rd <= exMem.rd;
      memWb.wdata <= exMem.memRead ? dMemRdata : exMem.aluResult;
   end

   assign wbFwd = memWb;
   assign rfWe = memWb.valid && memWb.regWrite;
   assign rfWa = memWb.rd;
   assign rfWd = memWb.wdata;

   // counted on entry to WB so the count already includes the SYSTEM op when halt rises
   always_ff @(posedge CLK) begin
      if (RSTn) begin
         numInst <= '0;
      end else if (exMem.valid) begin
         numInst <= numInst + 1;
      end
   end

   assign haltRetire = memWb.valid && memWb.isHalt;

   always_ff @(posedge CLK) begin
      if (RSTn) begin
         haltSeen <= 1'b0;
      end else if (haltRetire) begin
         haltSeen <= 1'b1;   // sticky until reset
      end
   end

   assign halt = haltSeen || haltRetire;

   // a store reaches memory only as a valid instruction, never after halt
   storeOnlyValid: assert property (@(posedge CLK) disable iff (RSTn)
      !dMemWen |-> exMem.valid && exMem.memWrite && !halt);

endmodule

//--- hw/riscvTop.sv
`timescale 1ns/1ps

module riscvTop #(
   parameter int addrWidth = 12
) (
   input  logic                       CLK,
   input  logic                       RSTn,
   output logic                       iMemCsn,
   input  logic [rvPkg::xlen-1:0]     iMemData,
   output logic [addrWidth-1:0]       iMemAddr,
   output logic                       dMemCsn,
   input  logic [rvPkg::xlen-1:0]     dMemRdata,
   output logic [rvPkg::xlen-1:0]     dMemWdata,
   output logic [addrWidth-1:0]       dMemAddr,
   output logic                       dMemWen,
   output logic                       rfWe,
   output logic [rvPkg::regAddrW-1:0] rfRa1,
   output logic [rvPkg::regAddrW-1:0] rfRa2,
   output logic [rvPkg::regAddrW-1:0] rfWa,
   input  logic [rvPkg::xlen-1:0]     rfRd1,
   input  logic [rvPkg::xlen-1:0]     rfRd2,
   output logic [rvPkg::xlen-1:0]     rfWd,
   output logic                       halt,
   output logic [rvPkg::xlen-1:0]     numInst
);

   logic [rvPkg::xlen-1:0] instId;
   logic [rvPkg::xlen-1:0] pcId;
   logic                   validId;
   logic                   stall;
   logic                   haltFetch;
   logic                   redirect;     // taken branch or jump, flushes IF/ID and ID/EX
   logic [rvPkg::xlen-1:0] redirectPc;
   rvPkg::idExT            idEx;
   rvPkg::exMemT           exMem;
   rvPkg::memWbT           wbFwd;

   fetchStage #(.addrWidth(addrWidth)) fetch (
      .CLK(CLK), .RSTn(RSTn), .stall(stall), .haltFetch(haltFetch),
      .redirect(redirect), .redirectPc(redirectPc), .iMemData(iMemData),
      .iMemAddr(iMemAddr), .iMemCsn(iMemCsn),
      .instId(instId), .pcId(pcId), .validId(validId)
   );

   decodeStage decode (
      .CLK(CLK), .RSTn(RSTn), .instId(instId), .pcId(pcId), .validId(validId),
      .flush(redirect), .rfRd1(rfRd1), .rfRd2(rfRd2), .wbFwd(wbFwd),
      .rfRa1(rfRa1), .rfRa2(rfRa2), .stall(stall), .haltFetch(haltFetch), .idEx(idEx)
   );

   executeStage execute (
      .CLK(CLK), .RSTn(RSTn), .idEx(idEx), .memFwd(exMem), .wbFwd(wbFwd),
      .redirect(redirect), .redirectPc(redirectPc), .exMem(exMem)
   );

   memWbStage #(.addrWidth(addrWidth)) memWb (
      .CLK(CLK), .RSTn(RSTn), .exMem(exMem), .dMemRdata(dMemRdata),
      .dMemAddr(dMemAddr), .dMemWdata(dMemWdata), .dMemWen(dMemWen), .dMemCsn(dMemCsn),
      .wbFwd(wbFwd), .rfWe(rfWe), .rfWa(rfWa), .rfWd(rfWd),
      .halt(halt), .numInst(numInst)
   );

endmodule

//--- hw/rvPkg.sv
package rvPkg;

   localparam int xlen = 32;    // data and pc width
   localparam int regAddrW = 5;

   // major opcodes of the supported RV32I subset
   typedef enum logic [6:0] {
      opReg    = 7'b0110011,
      opImm    = 7'b0010011,
      opLoad   = 7'b0000011,
      opStore  = 7'b0100011,
      opBranch = 7'b1100011,
      opJal    = 7'b1101111,
      opJalr   = 7'b1100111,
      opSystem = 7'b1110011
   } opcodeE;

   typedef enum logic [3:0] {
      aluAdd,
      aluSub,
      aluSll,
      aluSlt,
      aluSltu,
      aluXor,
      aluSrl,
      aluSra,
      aluOr,
      aluAnd
   } aluOpE;

   typedef struct packed {
      logic       regWrite;   // cleared for rd == x0
      logic       memRead;
      logic       memWrite;
      aluOpE      aluOp;
      logic       srcAPc;     // operand a is the pc
      logic       srcBImm;    // operand b is the immediate
      logic       isBranch;
      logic       isJal;
      logic       isJalr;
      logic       isHalt;
      logic [2:0] brCond;     // funct3 of a branch
   } ctrlT;

   typedef struct packed {
      logic                valid;
      ctrlT                ctrl;
      logic [xlen-1:0]     pc;
      logic [xlen-1:0]     rs1Val;
      logic [xlen-1:0]     rs2Val;
      logic [regAddrW-1:0] rs1;
      logic [regAddrW-1:0] rs2;
      logic [regAddrW-1:0] rd;
      logic [xlen-1:0]     imm;
   } idExT;

   typedef struct packed {
      logic                valid;
      logic                regWrite;
      logic                memRead;
      logic                memWrite;
      logic                isHalt;
      logic [xlen-1:0]     aluResult;   // link value for jumps
      logic [xlen-1:0]     storeData;
      logic [regAddrW-1:0] rd;
   } exMemT;

   typedef struct packed {
      logic                valid;
      logic                regWrite;
      logic                isHalt;
      logic [regAddrW-1:0] rd;
      logic [xlen-1:0]     wdata;
   } memWbT;

endpackage

//--- riscvPipe.f
hw/rvPkg.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/memWbStage.sv
hw/riscvTop.sv
tests/tbMemories.sv
tests/tbRiscvTop.sv

//--- tests/tbMemories.sv
`timescale 1ns/1ps

module tbMemories #(
   parameter int addrWidth = 12
) (
   input  logic                       CLK,
   input  logic                       iMemCsn,
   input  logic [addrWidth-1:0]       iMemAddr,
   output logic [rvPkg::xlen-1:0]     iMemData,
   input  logic                       dMemCsn,
   input  logic [addrWidth-1:0]       dMemAddr,
   input  logic [rvPkg::xlen-1:0]     dMemWdata,
   input  logic                       dMemWen,
   output logic [rvPkg::xlen-1:0]     dMemRdata,
   input  logic [rvPkg::regAddrW-1:0] rfRa1,
   input  logic [rvPkg::regAddrW-1:0] rfRa2,
   input  logic                       rfWe,
   input  logic [rvPkg::regAddrW-1:0] rfWa,
   input  logic [rvPkg::xlen-1:0]     rfWd,
   output logic [rvPkg::xlen-1:0]     rfRd1,
   output logic [rvPkg::xlen-1:0]     rfRd2
);

   localparam int words = 1 << (addrWidth - 2);

   logic [rvPkg::xlen-1:0] imem [0:words-1];
   logic [rvPkg::xlen-1:0] dmem [0:words-1];
   logic [rvPkg::xlen-1:0] rf [0:31];   // x0 stays zero, never written

   // word addressed, reads are combinational
   assign iMemData = iMemCsn ? '0 : imem[iMemAddr[addrWidth-1:2]];   // zero when deselected
   assign dMemRdata = dmem[dMemAddr[addrWidth-1:2]];
   assign rfRd1 = rf[rfRa1];
   assign rfRd2 = rf[rfRa2];

   always @(posedge CLK) begin
      if (!dMemCsn && !dMemWen) begin
         dmem[dMemAddr[addrWidth-1:2]] <= dMemWdata;
      end
      if (rfWe) begin
         rf[rfWa] <= rfWd;
      end
   end

endmodule

//--- tests/tbRiscvTop.sv
`timescale 1ns/1ps

module tbRiscvTop;

   localparam int addrWidth = 12;
   localparam int words = 1 << (addrWidth - 2);
   localparam int numBlocks = 60;

   logic                       CLK;
   logic                       RSTn;
   logic                       iMemCsn;
   logic [rvPkg::xlen-1:0]     iMemData;
   logic [addrWidth-1:0]       iMemAddr;
   logic                       dMemCsn;
   logic [rvPkg::xlen-1:0]     dMemRdata;
   logic [rvPkg::xlen-1:0]     dMemWdata;
   logic [addrWidth-1:0]       dMemAddr;
   logic                       dMemWen;
   logic                       rfWe;
   logic [rvPkg::regAddrW-1:0] rfRa1;
   logic [rvPkg::regAddrW-1:0] rfRa2;
   logic [rvPkg::regAddrW-1:0] rfWa;
   logic [rvPkg::xlen-1:0]     rfRd1;
   logic [rvPkg::xlen-1:0]     rfRd2;
   logic [rvPkg::xlen-1:0]     rfWd;
   logic                       halt;
   logic [rvPkg::xlen-1:0]     numInst;

   logic [31:0]                prog [0:words-1];
   logic [31:0]                refReg [0:31];
   logic [31:0]                refMem [0:words-1];
   logic [31:0]                refPc;
   logic [rvPkg::regAddrW-1:0] expRd [$];
   logic [rvPkg::xlen-1:0]     expVal [$];
   int                         seed;
   int                         progLen;
   int                         expCount;
   int                         cycles;
   int                         limit;
   bit                         done;

   riscvTop #(.addrWidth(addrWidth)) uut (
      .CLK(CLK), .RSTn(RSTn), .iMemCsn(iMemCsn), .iMemData(iMemData), .iMemAddr(iMemAddr),
      .dMemCsn(dMemCsn), .dMemRdata(dMemRdata), .dMemWdata(dMemWdata), .dMemAddr(dMemAddr),
      .dMemWen(dMemWen), .rfWe(rfWe), .rfRa1(rfRa1), .rfRa2(rfRa2), .rfWa(rfWa),
      .rfRd1(rfRd1), .rfRd2(rfRd2), .rfWd(rfWd), .halt(halt), .numInst(numInst)
   );

   tbMemories #(.addrWidth(addrWidth)) mem (
      .CLK(CLK), .iMemCsn(iMemCsn), .iMemAddr(iMemAddr), .iMemData(iMemData),
      .dMemCsn(dMemCsn), .dMemAddr(dMemAddr), .dMemWdata(dMemWdata), .dMemWen(dMemWen),
      .dMemRdata(dMemRdata), .rfRa1(rfRa1), .rfRa2(rfRa2), .rfWe(rfWe), .rfWa(rfWa),
      .rfWd(rfWd), .rfRd1(rfRd1), .rfRd2(rfRd2)
   );

   initial begin
      CLK = 1'b0;
      forever #10 CLK = ~CLK;
   end

   task automatic reportFail(input string msg);
      $display("%s", msg);
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

   task automatic checkWrite(input logic [rvPkg::regAddrW-1:0] rd,
                             input logic [rvPkg::xlen-1:0] val);
      logic [rvPkg::regAddrW-1:0] eRd;
      logic [rvPkg::xlen-1:0]     eVal;
      if (expRd.size() == 0) begin
         reportFail($sformatf("ERR %0t: unexpected write x%0d = %h", $time, rd, val));
      end else begin
         eRd = expRd.pop_front();
         eVal = expVal.pop_front();
         if (rd !== eRd || val !== eVal) begin
            reportFail($sformatf("ERR %0t: write x%0d = %h, expected x%0d = %h",
                                 $time, rd, val, eRd, eVal));
         end
      end
   endtask

   task automatic checkCount(input logic [rvPkg::xlen-1:0] got,
                             input logic [rvPkg::xlen-1:0] exp);
      if (got !== exp) begin
         reportFail($sformatf("ERR %0t: numInst %0d, expected %0d", $time, got, exp));
      end
   endtask

   task automatic checkFlag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         reportFail($sformatf("ERR %0t: %s is %b, expected %b", $time, name, got, exp));
      end
   endtask

   function automatic int pick(input int n);
      return $unsigned($random(seed)) % n;
   endfunction

   // instruction encoders
   function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
         input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, rvPkg::opReg};
   endfunction

   function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
         input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
         input logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rvPkg::opStore};
   endfunction

   function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
         input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rvPkg::opBranch};
   endfunction

   function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvPkg::opJal};
   endfunction

   task automatic emit(input logic [31:0] word);
      prog[progLen] = word;
      progLen++;
   endtask

   // one random R or I op on x0..x8, x0 targets check the no-write rule
   task automatic genAlu();
      logic [2:0]  f3;
      logic [11:0] imm;
      logic [4:0]  rd;
      f3 = pick(8);
      rd = pick(9);
      if (pick(2) == 1) begin
         emit(encR(((f3 == 3'd0 || f3 == 3'd5) && pick(2) == 1) ? 7'h20 : 7'h00,
                   pick(9), pick(9), f3, rd));
      end else begin
         imm = $random(seed);
         if (f3 == 3'd1) imm[11:5] = 7'h00;
         if (f3 == 3'd5) imm[11:5] = (pick(2) == 1) ? 7'h20 : 7'h00;   // srli or srai
         emit(encI(imm, pick(9), f3, rd, rvPkg::opImm));
      end
   endtask

   task automatic buildProgram();
      logic [2:0]  conds [0:5];
      logic [11:0] a;
      logic [11:0] b;
      logic [4:0]  rd;
      int          skip;
      conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
      for (int r = 1; r <= 8; r++) begin
         emit(encI($random(seed), 5'd0, 3'd0, r, rvPkg::opImm));
      end
      for (int blk = 0; blk < numBlocks; blk++) begin
         rd = 1 + pick(8);
         case (pick(6))
            0, 1: begin
               genAlu();
               genAlu();
            end
            2: begin   // store, load, then use the load at once
               a = pick(256) * 4;
               b = (pick(2) == 1) ? a : pick(256) * 4;
               emit(encS(a, pick(9), 5'd0));
               emit(encI(b, 5'd0, 3'b010, rd, rvPkg::opLoad));
               emit(encR(7'h00, rd, pick(9), 3'd0, 1 + pick(8)));
            end
            3: begin
               skip = 1 + pick(2);
               emit(encB((skip + 1) * 4, pick(9), pick(9), conds[pick(6)]));
               repeat (skip) genAlu();
            end
            4: begin
               emit(encJ(21'd8, rd));
               genAlu();
            end
            default: begin   // jalr to an absolute target built in x8
               emit(encI((progLen + 3) * 4, 5'd0, 3'd0, 5'd8, rvPkg::opImm));
               emit(encI(12'd0, 5'd8, 3'd0, rd, rvPkg::opJalr));
               genAlu();
            end
         endcase
      end
      emit(32'h0000_0073);   // ecall, ends the run
   endtask

   function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
         input logic [31:0] a, input logic [31:0] b);
      case (f3)
         3'd0:    return alt ? a - b : a + b;
         3'd1:    return a << b[4:0];
         3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'd3:    return (a < b) ? 32'd1 : 32'd0;
         3'd4:    return a ^ b;
         3'd5:    return alt ? $signed(a) >>> b[4:0] : a >> b[4:0];
         3'd6:    return a | b;
         default: return a & b;
      endcase
   endfunction

   // executes one instruction at refPc, returns 1 on the SYSTEM op
   function automatic bit isaStep();
      logic [31:0] ins;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] immI;
      logic [31:0] res;
      logic [31:0] addr;
      logic [31:0] nextPc;
      logic [4:0]  rd;
      logic [2:0]  f3;
      logic        wr;
      logic        tk;
      ins = prog[refPc[addrWidth-1:2]];
      a = refReg[ins[19:15]];
      b = refReg[ins[24:20]];
      rd = ins[11:7];
      f3 = ins[14:12];
      immI = {{20{ins[31]}}, ins[31:20]};
      nextPc = refPc + 4;
      wr = 1'b0;
      res = '0;
      expCount++;
      case (ins[6:0])
         7'b0110011: begin
            wr = 1'b1;
            res = aluRef(f3, ins[30], a, b);
         end
         7'b0010011: begin
            wr = 1'b1;
            res = aluRef(f3, ins[30] && f3 == 3'd5, a, immI);
         end
         7'b0000011: begin
            addr = a + immI;
            wr = 1'b1;
            res = refMem[addr[addrWidth-1:2]];
         end
         7'b0100011: begin
            addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
            refMem[addr[addrWidth-1:2]] = b;
         end
         7'b1100011: begin
            case (f3)
               3'd0:    tk = a == b;
               3'd1:    tk = a != b;
               3'd4:    tk = $signed(a) < $signed(b);
               3'd5:    tk = $signed(a) >= $signed(b);
               3'd6:    tk = a < b;
               default: tk = a >= b;
            endcase
            if (tk) nextPc = refPc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
         end
         7'b1101111: begin
            wr = 1'b1;
            res = refPc + 4;
            nextPc = refPc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
         end
         7'b1100111: begin
            wr = 1'b1;
            res = refPc + 4;
            nextPc = (a + immI) & ~32'd1;
         end
         default: return 1'b1;
      endcase
      if (wr && rd != 5'd0) begin
         refReg[rd] = res;
         expRd.push_back(rd);
         expVal.push_back(res);
      end
      refPc = nextPc;
      return 1'b0;
   endfunction

   // write compare, mid cycle where rfWe and its data are settled
   always @(negedge CLK) begin
      if (!RSTn && rfWe) checkWrite(rfWa, rfWd);
   end

   always @(posedge CLK) begin
      if (!RSTn && !done) begin
         cycles++;
         if (cycles > limit) reportFail("timeout: halt did not rise within the cycle limit");
      end
   end

   initial begin
      seed = 32'h47b2_4575;
      RSTn = 1'b1;
      done = 1'b0;
      cycles = 0;
      progLen = 0;
      expCount = 0;
      for (int i = 0; i < words; i++) prog[i] = '0;
      buildProgram();
      for (int i = 0; i < words; i++) begin
         refMem[i] = (i * 32'h0001_0003) ^ 32'h5a5a_0f0f;   // address dependent fill
         mem.dmem[i] = refMem[i];
         mem.imem[i] = prog[i];
      end
      for (int r = 0; r < 32; r++) begin
         refReg[r] = '0;
         mem.rf[r] = '0;
      end
      refPc = '0;
      while (!isaStep()) begin
      end
      limit = 3 * expCount + 50;

      repeat (8) begin
         @(negedge CLK);
         checkFlag("rfWe", rfWe, 1'b0);
         checkFlag("dMemWen", dMemWen, 1'b1);
         checkFlag("halt", halt, 1'b0);
         checkFlag("iMemCsn", iMemCsn, 1'b1);
         checkFlag("dMemCsn", dMemCsn, 1'b1);
         checkCount(numInst, '0);
      end
      RSTn = 1'b0;
      @(negedge CLK);
      checkFlag("iMemCsn", iMemCsn, 1'b0);
      checkFlag("dMemCsn", dMemCsn, 1'b0);

      while (!halt) @(negedge CLK);
      done = 1'b1;
      checkCount(numInst, expCount);
      repeat (10) begin   // nothing may write after halt
         @(negedge CLK);
         checkFlag("halt", halt, 1'b1);
      end
      if (expRd.size() != 0) begin
         reportFail($sformatf("%0d expected register writes never happened", expRd.size()));
      end else begin
         $display("PASS: all tests");
         $finish;
      end
   end

endmodule
